// ==== hdl/trace_defines.svh ====
// commit-trace classifier widths and class count
`ifndef TRACE_DEFINES_SVH
`define TRACE_DEFINES_SVH

// instruction word as seen on the commit port
`define TRACE_ILEN      32

// architectural register index
`define TRACE_REG_W     5

// per-class commit counters, wrap on overflow
`define TRACE_CNT_W     16

// instruction classes and the select that picks one
`define TRACE_N_CLASS   8
`define TRACE_SEL_W     3

`endif

// ==== hdl/trace_pkg.sv ====
// commit-trace classifier types: class enum, word views and decoded record
`include "trace_defines.svh"

package trace_pkg;

    // fence, ecall, ebreak and mret are counted as CSR
    typedef enum logic [`TRACE_SEL_W-1:0] {
        BASE,
        MEXT,
        LOAD,
        STORE,
        BRANCH,
        JAL,
        JALR,
        CSR
    } itype_e;

    // **********************************************************************
    // two views of one committed word
    // **********************************************************************
    typedef struct packed {
        logic [6:0]              funct7;
        logic [`TRACE_REG_W-1:0] rs2;
        logic [`TRACE_REG_W-1:0] rs1;
        logic [2:0]              funct3;
        logic [`TRACE_REG_W-1:0] rd;
        logic [6:0]              opcode;
    } rvi_fields_t;

    typedef struct packed {
        logic [`TRACE_ILEN-17:0] upper;   // not part of a compressed word
        logic [2:0]              funct3;
        logic                    b12;
        logic [4:0]              f11_7;
        logic [4:0]              f6_2;
        logic [1:0]              op;      // length bits, 11 means 32-bit
    } rvc_fields_t;

    typedef union packed {
        rvi_fields_t rvi;
        rvc_fields_t rvc;
    } instr_word_u;

    // register usage, unused fields read zero
    typedef struct packed {
        logic [`TRACE_REG_W-1:0] rs1;
        logic [`TRACE_REG_W-1:0] rs2;
        logic                    rs1_used;
        logic                    rs2_used;
        logic [`TRACE_REG_W-1:0] rd;
        logic                    rd_used;
    } reg_use_t;

    typedef struct packed {
        itype_e   itype;
        reg_use_t regs;
        logic     is_rvc;
        logic     raw;     // read-after-write on the previous record
    } trace_rec_t;

endpackage

// ==== hdl/rvi_decoder.sv ====
// class and register usage decode of 32-bit RV32IM instruction words
`timescale 1ns/1ps

module rvi_decoder (
    input  trace_pkg::rvi_fields_t instr_i,
    output trace_pkg::itype_e      itype_o,
    output trace_pkg::reg_use_t    use_o
);

    always_comb begin
        itype_o = trace_pkg::BASE;
        use_o   = '0;
        case (instr_i.opcode[6:2])
            5'b01101, 5'b00101: begin // lui, auipc
                use_o.rd      = instr_i.rd;
                use_o.rd_used = 1'b1;
            end
            5'b11011: begin // jal
                itype_o       = trace_pkg::JAL;
                use_o.rd      = instr_i.rd;
                use_o.rd_used = 1'b1;
            end
            5'b11001: begin // jalr
                itype_o        = trace_pkg::JALR;
                use_o.rs1      = instr_i.rs1;
                use_o.rs1_used = 1'b1;
                use_o.rd       = instr_i.rd;
                use_o.rd_used  = 1'b1;
            end
            5'b00000: begin
                itype_o        = trace_pkg::LOAD;
                use_o.rs1      = instr_i.rs1;
                use_o.rs1_used = 1'b1;
                use_o.rd       = instr_i.rd;
                use_o.rd_used  = 1'b1;
            end
            5'b01000, 5'b11000: begin // store and branch have no destination
                itype_o        = instr_i.opcode[6] ? trace_pkg::BRANCH : trace_pkg::STORE;
                use_o.rs1      = instr_i.rs1;
                use_o.rs1_used = 1'b1;
                use_o.rs2      = instr_i.rs2;
                use_o.rs2_used = 1'b1;
            end
            5'b00100: begin // op-imm
                use_o.rs1      = instr_i.rs1;
                use_o.rs1_used = 1'b1;
                use_o.rd       = instr_i.rd;
                use_o.rd_used  = 1'b1;
            end
            5'b01100: begin
                if (instr_i.funct7 == 7'b0000001) begin
                    itype_o = trace_pkg::MEXT;
                end
                use_o.rs1      = instr_i.rs1;
                use_o.rs1_used = 1'b1;
                use_o.rs2      = instr_i.rs2;
                use_o.rs2_used = 1'b1;
                use_o.rd       = instr_i.rd;
                use_o.rd_used  = 1'b1;
            end
            5'b00011: begin
                itype_o = trace_pkg::CSR; // fence
            end
            5'b11100: begin
                itype_o = trace_pkg::CSR;
                if (instr_i.funct3 != 3'b000) begin
                    use_o.rd      = instr_i.rd;
                    use_o.rd_used = 1'b1;
                    if (!instr_i.funct3[2]) begin // register form, immediate forms read no rs1
                        use_o.rs1      = instr_i.rs1;
                        use_o.rs1_used = 1'b1;
                    end
                end
            end
            default: begin
                itype_o = trace_pkg::BASE;
            end
        endcase
    end

endmodule

// ==== hdl/rvc_decoder.sv ====
// class and register usage decode of 16-bit compressed instruction words
`timescale 1ns/1ps
`include "trace_defines.svh"

module rvc_decoder (
    input  trace_pkg::rvc_fields_t instr_i,
    output trace_pkg::itype_e      itype_o,
    output trace_pkg::reg_use_t    use_o
);

    logic [`TRACE_REG_W-1:0] rs1p;  // x8..x15 from bits 9:7
    logic [`TRACE_REG_W-1:0] rs2p;  // x8..x15 from bits 4:2
    logic                    rd_zero;
    logic                    lo_zero;
    logic                    imm6_zero;

    assign rs1p      = {2'b01, instr_i.f11_7[2:0]};
    assign rs2p      = {2'b01, instr_i.f6_2[2:0]};
    assign rd_zero   = (instr_i.f11_7 == 5'd0);
    assign lo_zero   = (instr_i.f6_2 == 5'd0);
    assign imm6_zero = lo_zero & ~instr_i.b12;

    always_comb begin
        itype_o = trace_pkg::BASE;
        use_o   = '0;
        case ({instr_i.op, instr_i.funct3})
            // *****************************************************************
            // quadrant 00
            // *****************************************************************
            5'b00_000: begin // addi4spn, zero immediate is reserved
                if ({instr_i.b12, instr_i.f11_7, instr_i.f6_2[4:3]} != 8'd0) begin
                    use_o.rs1      = 5'd2;
                    use_o.rs1_used = 1'b1;
                    use_o.rd       = rs2p;
                    use_o.rd_used  = 1'b1;
                end
            end
            5'b00_010: begin
                itype_o        = trace_pkg::LOAD;
                use_o.rs1      = rs1p;
                use_o.rs1_used = 1'b1;
                use_o.rd       = rs2p;
                use_o.rd_used  = 1'b1;
            end
            5'b00_110: begin
                itype_o        = trace_pkg::STORE;
                use_o.rs1      = rs1p;
                use_o.rs1_used = 1'b1;
                use_o.rs2      = rs2p;
                use_o.rs2_used = 1'b1;
            end
            // *****************************************************************
            // quadrant 01
            // *****************************************************************
            5'b01_000: begin // c.nop when rd is x0
                use_o.rs1      = instr_i.f11_7;
                use_o.rs1_used = ~rd_zero;
                use_o.rd       = instr_i.f11_7;
                use_o.rd_used  = ~rd_zero;
            end
            5'b01_001: begin
                itype_o       = trace_pkg::JAL;
                use_o.rd      = 5'd1;
                use_o.rd_used = 1'b1;
            end
            5'b01_010: begin // c.li
                use_o.rd      = instr_i.f11_7;
                use_o.rd_used = 1'b1;
            end
            5'b01_011: begin
                if (!imm6_zero) begin
                    use_o.rd      = instr_i.f11_7;
                    use_o.rd_used = 1'b1;
                    if (instr_i.f11_7 == 5'd2) begin // addi16sp
                        use_o.rs1      = 5'd2;
                        use_o.rs1_used = 1'b1;
                    end
                end
            end
            5'b01_100: begin
                if (instr_i.f11_7[4:3] == 2'b10 || !lo_zero && !instr_i.f11_7[4]) begin
                    use_o.rs1      = rs1p;  // andi, srli, srai
                    use_o.rs1_used = 1'b1;
                    use_o.rd       = rs1p;
                    use_o.rd_used  = 1'b1;
                end else if (instr_i.f11_7[4:3] == 2'b11 && !instr_i.b12) begin
                    use_o.rs1      = rs1p;
                    use_o.rs1_used = 1'b1;
                    use_o.rs2      = rs2p;
                    use_o.rs2_used = 1'b1;
                    use_o.rd       = rs1p;
                    use_o.rd_used  = 1'b1;
                end
            end
            5'b01_101: begin
                itype_o = trace_pkg::JAL; // c.j links nothing
            end
            5'b01_110, 5'b01_111: begin // beqz, bnez
                itype_o        = trace_pkg::BRANCH;
                use_o.rs1      = rs1p;
                use_o.rs1_used = 1'b1;
            end
            // *****************************************************************
            // quadrant 10
            // *****************************************************************
            5'b10_000: begin
                if (!instr_i.b12 && !rd_zero && !lo_zero) begin // slli
                    use_o.rs1      = instr_i.f11_7;
                    use_o.rs1_used = 1'b1;
                    use_o.rd       = instr_i.f11_7;
                    use_o.rd_used  = 1'b1;
                end
            end
            5'b10_010: begin
                if (!rd_zero) begin // lwsp
                    itype_o        = trace_pkg::LOAD;
                    use_o.rs1      = 5'd2;
                    use_o.rs1_used = 1'b1;
                    use_o.rd       = instr_i.f11_7;
                    use_o.rd_used  = 1'b1;
                end
            end
            5'b10_100: begin
                if (!lo_zero) begin // mv or add
                    use_o.rs1      = instr_i.b12 ? instr_i.f11_7 : 5'd0;
                    use_o.rs1_used = instr_i.b12;
                    use_o.rs2      = instr_i.f6_2;
                    use_o.rs2_used = 1'b1;
                    use_o.rd       = instr_i.f11_7;
                    use_o.rd_used  = 1'b1;
                end else if (!rd_zero) begin // jr or jalr
                    itype_o        = trace_pkg::JALR;
                    use_o.rs1      = instr_i.f11_7;
                    use_o.rs1_used = 1'b1;
                    use_o.rd       = instr_i.b12 ? 5'd1 : 5'd0;
                    use_o.rd_used  = instr_i.b12;
                end else if (instr_i.b12) begin
                    itype_o = trace_pkg::CSR; // ebreak
                end
            end
            5'b10_110: begin // swsp, stored value in bits 6:2
                itype_o        = trace_pkg::STORE;
                use_o.rs1      = 5'd2;
                use_o.rs1_used = 1'b1;
                use_o.rs2      = instr_i.f6_2;
                use_o.rs2_used = 1'b1;
            end
            default: begin
                itype_o = trace_pkg::BASE; // reserved
            end
        endcase
    end

endmodule

// ==== hdl/decode_stage.sv ====
// decode stage, picks the 32-bit or compressed decode and registers the record
`timescale 1ns/1ps

module decode_stage (
    input  logic                   s_clk_i,
    input  logic                   reset_i,
    input  logic                   valid_i,
    input  trace_pkg::instr_word_u instr_i,
    output logic                   valid_o,
    output trace_pkg::trace_rec_t  rec_o
);

    trace_pkg::itype_e   rvi_itype;
    trace_pkg::reg_use_t rvi_use;
    trace_pkg::itype_e   rvc_itype;
    trace_pkg::reg_use_t rvc_use;
    logic                is_rvc;

    rvi_decoder rvi_dec0 (
        .instr_i (instr_i.rvi),
        .itype_o (rvi_itype),
        .use_o   (rvi_use)
    );

    rvc_decoder rvc_dec0 (
        .instr_i (instr_i.rvc),
        .itype_o (rvc_itype),
        .use_o   (rvc_use)
    );

    assign is_rvc = (instr_i.rvc.op != 2'b11);

    always_ff @(posedge s_clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (valid_i) begin
            rec_o.itype  <= is_rvc ? rvc_itype : rvi_itype;
            rec_o.regs   <= is_rvc ? rvc_use : rvi_use;
            rec_o.is_rvc <= is_rvc;
            rec_o.raw    <= 1'b0; // filled in by the next stage
        end
    end

endmodule

// ==== hdl/dep_execute.sv ====
// execute stage, flags read-after-write against the previous record
`timescale 1ns/1ps

module dep_execute (
    input  logic                  s_clk_i,
    input  logic                  reset_i,
    input  logic                  valid_i,
    input  trace_pkg::trace_rec_t rec_i,
    output logic                  valid_o,
    output trace_pkg::trace_rec_t rec_o
);

    logic [4:0] prev_rd;
    logic       prev_rd_used;  // cleared by reset, so no previous record
    logic       prev_live;
    logic       raw;

    assign prev_live = prev_rd_used && (prev_rd != 5'd0);  // x0 never carries a dependency

    assign raw = prev_live &&
                 ((rec_i.regs.rs1_used && rec_i.regs.rs1 == prev_rd) ||
                  (rec_i.regs.rs2_used && rec_i.regs.rs2 == prev_rd));

    always_ff @(posedge s_clk_i) begin
        if (reset_i) begin
            valid_o      <= 1'b0;
            prev_rd_used <= 1'b0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                prev_rd_used <= rec_i.regs.rd_used;
            end
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (valid_i) begin
            prev_rd   <= rec_i.regs.rd;
            rec_o     <= rec_i;
            rec_o.raw <= raw;
        end
    end

endmodule

// ==== hdl/class_counters.sv ====
// per-class commit counters with combinational readback
`timescale 1ns/1ps
`include "trace_defines.svh"

module class_counters (
    input  logic                    s_clk_i,
    input  logic                    reset_i,
    input  logic                    valid_i,
    input  trace_pkg::itype_e       itype_i,
    input  trace_pkg::itype_e       sel_i,
    output logic [`TRACE_CNT_W-1:0] count_o
);

    logic [`TRACE_CNT_W-1:0] cnt_q [`TRACE_N_CLASS];

    // *********************************************************************
    // one wrapping counter per class
    // *********************************************************************
    always_ff @(posedge s_clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `TRACE_N_CLASS; i++) begin
                cnt_q[i] <= '0;
            end
        end else if (valid_i) begin
            cnt_q[itype_i] <= cnt_q[itype_i] + 1'b1;  // wraps at 2^16
        end
    end

    assign count_o = cnt_q[sel_i];  // stored value, no bypass of this cycle's strobe

endmodule

// ==== hdl/trace_top.sv ====
// commit-trace classifier top, decode then dependency check then class counters
`timescale 1ns/1ps
`include "trace_defines.svh"

module trace_top (
    input  logic                    s_clk_i,
    input  logic                    reset_i,
    input  logic                    commit_valid_i,
    input  trace_pkg::instr_word_u  commit_instr_i,
    input  trace_pkg::itype_e       cnt_sel_i,
    output logic                    rec_valid_o,
    output trace_pkg::trace_rec_t   rec_o,
    output logic [`TRACE_CNT_W-1:0] cnt_o
);

    logic                  dec_valid;
    trace_pkg::trace_rec_t dec_rec;

    decode_stage dec0 (
        .s_clk_i (s_clk_i),
        .reset_i (reset_i),
        .valid_i (commit_valid_i),
        .instr_i (commit_instr_i),
        .valid_o (dec_valid),
        .rec_o   (dec_rec)
    );

    dep_execute exe0 (
        .s_clk_i (s_clk_i),
        .reset_i (reset_i),
        .valid_i (dec_valid),
        .rec_i   (dec_rec),
        .valid_o (rec_valid_o),
        .rec_o   (rec_o)
    );

    class_counters cnt0 (
        .s_clk_i (s_clk_i),
        .reset_i (reset_i),
        .valid_i (rec_valid_o),
        .itype_i (rec_o.itype),
        .sel_i   (cnt_sel_i),
        .count_o (cnt_o)
    );

endmodule

// ==== sim/trace_props.sv ====
// concurrent checks on the commit-trace classifier top level
`timescale 1ns/1ps

module trace_props (
    input logic                  s_clk_i,
    input logic                  reset_i,
    input logic                  commit_valid_i,
    input logic                  rec_valid_o,
    input trace_pkg::trace_rec_t rec_o
);

    // record strobe is the commit strobe two cycles later
    a_latency: assert property (@(posedge s_clk_i) disable iff (reset_i)
        (!$past(reset_i) && !$past(reset_i, 2)) |->
            (rec_valid_o == $past(commit_valid_i, 2)))
        else $error("record strobe does not follow the commit strobe by two cycles");

    a_unused_zero: assert property (@(posedge s_clk_i) rec_valid_o |->
        (rec_o.regs.rs1_used || rec_o.regs.rs1 == 5'd0) &&
        (rec_o.regs.rs2_used || rec_o.regs.rs2 == 5'd0) &&
        (rec_o.regs.rd_used || rec_o.regs.rd == 5'd0))
        else $error("unused register field is not zero");

    a_reset_quiet: assert property (@(posedge s_clk_i) $past(reset_i) |-> !rec_valid_o)
        else $error("record emitted while in reset");

endmodule

bind trace_top trace_props props0 (
    .s_clk_i        (s_clk_i),
    .reset_i        (reset_i),
    .commit_valid_i (commit_valid_i),
    .rec_valid_o    (rec_valid_o),
    .rec_o          (rec_o)
);

// ==== sim/trace_tb.sv ====
// testbench that checks random commits to the commit-trace classifier against a model
`timescale 1ns/1ps
`include "trace_defines.svh"

module trace_tb;

    localparam int N_COMMITS = 2000;
    localparam int MAX_CYC   = 10000;  // 4 cycles per commit at worst plus reset and readback

    localparam logic [4:0] OPCODES [11] = '{
        5'b01101, 5'b00101, 5'b11011, 5'b11001, 5'b00000, 5'b01000,
        5'b11000, 5'b00100, 5'b01100, 5'b00011, 5'b11100
    };

    logic                    s_clk;
    logic                    reset;
    logic                    commit_valid;
    trace_pkg::instr_word_u  commit_instr;
    trace_pkg::itype_e       cnt_sel;
    logic                    rec_valid;
    trace_pkg::trace_rec_t   rec;
    logic [`TRACE_CNT_W-1:0] cnt;

    logic [31:0]             lcg_state;
    int                      cyc;
    int                      gap;
    trace_pkg::trace_rec_t   exp_q [$];
    int                      stamp_q [$];   // cycle of each queued commit
    trace_pkg::trace_rec_t   mon_exp;
    int                      mon_stamp;
    logic [`TRACE_REG_W-1:0] prev_rd;
    logic                    prev_rd_used;
    logic [`TRACE_CNT_W-1:0] model_cnt [`TRACE_N_CLASS];

    trace_top dut0 (
        .s_clk_i        (s_clk),
        .reset_i        (reset),
        .commit_valid_i (commit_valid),
        .commit_instr_i (commit_instr),
        .cnt_sel_i      (cnt_sel),
        .rec_valid_o    (rec_valid),
        .rec_o          (rec),
        .cnt_o          (cnt)
    );

    always #50 s_clk = ~s_clk;

    always @(posedge s_clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYC) begin
            $display("run did not finish within %0d cycles", MAX_CYC);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    // **********************************************************************
    // stimulus helpers
    // **********************************************************************
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 16);
    endfunction

    // x0..x3 or x8..x11 so compressed and 32-bit words share registers
    function automatic logic [4:0] small_reg(input logic [2:0] r);
        return {1'b0, r[2], 1'b0, r[1:0]};
    endfunction

    function automatic logic [31:0] make_word();
        logic [31:0] w;
        logic [31:0] r;
        w = next_rand();
        r = next_rand();
        if (r[1:0] != 2'b00) begin  // template unless the raw random word is kept
            w[11:7]  = small_reg(r[4:2]);
            w[19:15] = small_reg(r[7:5]);
            w[24:20] = small_reg(r[10:8]);
            if (r[11]) begin
                w[1:0] = 2'b11;
                w[6:2] = OPCODES[int'(r[31:26]) % 11];
                if (r[12]) begin
                    w[31:25] = {6'd0, r[13]};  // plain op or m-extension
                end
            end else begin
                w[6:2] = small_reg(r[16:14]);
                w[1:0] = 2'(int'(r[31:26]) % 3);
            end
        end
        return w;
    endfunction

    // **********************************************************************
    // reference model of the class and register decode
    // **********************************************************************
    function automatic trace_pkg::trace_rec_t model_decode(input logic [31:0] w);
        trace_pkg::trace_rec_t r;
        trace_pkg::itype_e     cls;
        logic [4:0]            s1;
        logic [4:0]            s2;
        logic [4:0]            d;
        logic                  u1;
        logic                  u2;
        logic                  ud;
        logic [4:0]            hi;
        logic [4:0]            lo;
        logic [4:0]            p1;
        logic [4:0]            p2;
        cls = trace_pkg::BASE;
        u1  = 1'b0;
        u2  = 1'b0;
        ud  = 1'b0;
        hi  = w[11:7];
        lo  = w[6:2];
        p1  = {2'b01, w[9:7]};
        p2  = {2'b01, w[4:2]};
        s1  = w[19:15];
        s2  = w[24:20];
        d   = hi;
        if (w[1:0] == 2'b11) begin
            case (w[6:2])
                5'b01101, 5'b00101: ud = 1'b1;
                5'b11011: begin
                    cls = trace_pkg::JAL;
                    ud  = 1'b1;
                end
                5'b11001, 5'b00000: begin
                    cls = w[6] ? trace_pkg::JALR : trace_pkg::LOAD;
                    u1  = 1'b1;
                    ud  = 1'b1;
                end
                5'b01000, 5'b11000: begin
                    cls = w[6] ? trace_pkg::BRANCH : trace_pkg::STORE;
                    u1  = 1'b1;
                    u2  = 1'b1;
                end
                5'b00100: begin
                    u1 = 1'b1;
                    ud = 1'b1;
                end
                5'b01100: begin
                    cls = (w[31:25] == 7'b0000001) ? trace_pkg::MEXT : trace_pkg::BASE;
                    u1  = 1'b1;
                    u2  = 1'b1;
                    ud  = 1'b1;
                end
                5'b00011: cls = trace_pkg::CSR;
                5'b11100: begin
                    cls = trace_pkg::CSR;
                    ud  = (w[14:12] != 3'b000);
                    u1  = (w[14:12] != 3'b000) && !w[14];
                end
                default: cls = trace_pkg::BASE;
            endcase
        end else begin
            case ({w[1:0], w[15:13]})
                5'b00_000: begin
                    if (w[12:5] != 8'd0) begin
                        s1 = 5'd2;
                        u1 = 1'b1;
                        d  = p2;
                        ud = 1'b1;
                    end
                end
                5'b00_010: begin
                    cls = trace_pkg::LOAD;
                    s1  = p1;
                    u1  = 1'b1;
                    d   = p2;
                    ud  = 1'b1;
                end
                5'b00_110: begin
                    cls = trace_pkg::STORE;
                    s1  = p1;
                    u1  = 1'b1;
                    s2  = p2;
                    u2  = 1'b1;
                end
                5'b01_000: begin
                    s1 = hi;
                    u1 = (hi != 5'd0);
                    ud = (hi != 5'd0);
                end
                5'b01_001: begin
                    cls = trace_pkg::JAL;
                    d   = 5'd1;
                    ud  = 1'b1;
                end
                5'b01_010: ud = 1'b1;
                5'b01_011: begin
                    if ({w[12], lo} != 6'd0) begin
                        ud = 1'b1;
                        s1 = 5'd2;
                        u1 = (hi == 5'd2);
                    end
                end
                5'b01_100: begin
                    d = p1;
                    s1 = p1;
                    s2 = p2;
                    if (hi[4:3] == 2'b10 || (!hi[4] && lo != 5'd0)) begin
                        u1 = 1'b1;
                        ud = 1'b1;
                    end else if (hi[4:3] == 2'b11 && !w[12]) begin
                        u1 = 1'b1;
                        u2 = 1'b1;
                        ud = 1'b1;
                    end
                end
                5'b01_101: cls = trace_pkg::JAL;
                5'b01_110, 5'b01_111: begin
                    cls = trace_pkg::BRANCH;
                    s1  = p1;
                    u1  = 1'b1;
                end
                5'b10_000: begin
                    s1 = hi;
                    u1 = !w[12] && hi != 5'd0 && lo != 5'd0;
                    ud = u1;
                end
                5'b10_010: begin
                    if (hi != 5'd0) begin
                        cls = trace_pkg::LOAD;
                        s1  = 5'd2;
                        u1  = 1'b1;
                        ud  = 1'b1;
                    end
                end
                5'b10_100: begin
                    s1 = hi;
                    s2 = lo;
                    if (lo != 5'd0) begin  // mv reads rs2 only and add reads both
                        u1 = w[12];
                        u2 = 1'b1;
                        ud = 1'b1;
                    end else if (hi != 5'd0) begin
                        cls = trace_pkg::JALR;
                        u1  = 1'b1;
                        d   = 5'd1;
                        ud  = w[12];
                    end else if (w[12]) begin
                        cls = trace_pkg::CSR;
                    end
                end
                5'b10_110: begin
                    cls = trace_pkg::STORE;
                    s1  = 5'd2;
                    u1  = 1'b1;
                    s2  = lo;
                    u2  = 1'b1;
                end
                default: cls = trace_pkg::BASE;
            endcase
        end
        r               = '0;
        r.itype         = cls;
        r.regs.rs1      = u1 ? s1 : 5'd0;
        r.regs.rs1_used = u1;
        r.regs.rs2      = u2 ? s2 : 5'd0;
        r.regs.rs2_used = u2;
        r.regs.rd       = ud ? d : 5'd0;
        r.regs.rd_used  = ud;
        r.is_rvc        = (w[1:0] != 2'b11);
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %0h actual %0h", name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_counts(input string name);
        for (int k = 0; k < `TRACE_N_CLASS; k++) begin
            @(posedge s_clk);
            cnt_sel <= trace_pkg::itype_e'(k);
            @(negedge s_clk);
            check(name, 32'(model_cnt[k]), 32'(cnt));
        end
    endtask

    // **********************************************************************
    // monitor sampling the outputs on the falling edge
    // **********************************************************************
    always @(negedge s_clk) begin
        if (stamp_q.size() != 0 && stamp_q[0] + 2 == cyc) begin
            check("record strobe", 32'd1, 32'(rec_valid));
        end
        if (rec_valid) begin
            if (exp_q.size() == 0) begin
                $display("a record came out with no commit waiting for it");
                $display("TEST FAIL");
                $fatal(1, "unexpected record");
            end else begin
                mon_exp   = exp_q.pop_front();
                mon_stamp = stamp_q.pop_front();
                check("record latency", mon_stamp + 2, cyc);
                check("record fields", 32'(mon_exp), 32'(rec));
            end
        end
        if (commit_valid && !reset) begin
            mon_exp     = model_decode(commit_instr);
            mon_exp.raw = prev_rd_used && prev_rd != 5'd0 &&
                          ((mon_exp.regs.rs1_used && mon_exp.regs.rs1 == prev_rd) ||
                           (mon_exp.regs.rs2_used && mon_exp.regs.rs2 == prev_rd));
            prev_rd      = mon_exp.regs.rd;
            prev_rd_used = mon_exp.regs.rd_used;
            model_cnt[mon_exp.itype] = model_cnt[mon_exp.itype] + 1'b1;
            exp_q.push_back(mon_exp);
            stamp_q.push_back(cyc);
        end
    end

    initial begin
        s_clk        = 1'b0;
        reset        = 1'b1;
        commit_valid = 1'b0;
        commit_instr = '0;
        cnt_sel      = trace_pkg::BASE;
        lcg_state    = 32'hb6b6;
        cyc          = 0;
        prev_rd      = '0;
        prev_rd_used = 1'b0;
        for (int k = 0; k < `TRACE_N_CLASS; k++) begin
            model_cnt[k] = '0;
        end
        repeat (3) begin
            @(posedge s_clk);
            commit_valid <= 1'b1;  // dropped while reset is held
            commit_instr <= make_word();
        end
        @(posedge s_clk);
        reset        <= 1'b0;
        commit_valid <= 1'b0;
        check_counts("counts after reset");
        for (int n = 0; n < N_COMMITS; n++) begin
            @(posedge s_clk);
            commit_valid <= 1'b1;
            commit_instr <= make_word();
            gap = int'(next_rand() % 4);  // zero gap gives back-to-back commits
            repeat (gap) begin
                @(posedge s_clk);
                commit_valid <= 1'b0;
            end
        end
        @(posedge s_clk);
        commit_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge s_clk);
        end
        repeat (2) @(posedge s_clk);
        check_counts("counts after last commit");
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/trace_pkg.sv
hdl/rvi_decoder.sv
hdl/rvc_decoder.sv
hdl/decode_stage.sv
hdl/dep_execute.sv
hdl/class_counters.sv
hdl/trace_top.sv
sim/trace_props.sv
sim/trace_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the commit-trace classifier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module trace_tb \
    -o trace_sim

# exit status is nonzero on any failing end of the run
./obj_dir/trace_sim
